//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_snes_mem_ctrl
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
verilog/snes_mem_pkg.sv
verilog/snes_bus_sync.sv
verilog/mcu_bridge.sv
verilog/rom_port.sv
verilog/ram_port.sv
verilog/snes_mem_ctrl.sv
testbench/tb_mem_model.sv
testbench/tb_snes_mem_ctrl.sv

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
  import snes_mem_pkg::*;
(
  input  logic        CLK2,
  input  rom_pins_t   rom,
  output logic [15:0] rom_rdata,
  input  ram_pins_t   ram,
  output logic [7:0]  ram_rdata
);
  // sparse storage, only written locations are kept
  logic [15:0] psram [logic [rom_addr_w-1:0]];
  logic [7:0]  sram  [logic [ram_addr_w-1:0]];

  // unwritten words read back a pattern built from every address bit
  function automatic logic [15:0] read_psram_word(input logic [rom_addr_w-1:0] a);
    if (psram.exists(a)) return psram[a];
    return a[15:0] ^ {2'b10, a[22:16], 7'h35};
  endfunction

  function automatic logic [7:0] read_sram_byte(input logic [ram_addr_w-1:0] a);
    if (sram.exists(a)) return sram[a];
    return a[7:0] ^ a[15:8] ^ {5'b01011, a[18:16]};
  endfunction

  // ------------------------------
  // write side
  // ------------------------------
  always @(posedge CLK2) begin : psram_write
    logic [15:0] word;
    if (!rom.we_n) begin
      word = read_psram_word(rom.addr);
      if (!rom.bhe_n) word[15:8] = rom.wdata[15:8];  // even byte lane
      if (!rom.ble_n) word[7:0] = rom.wdata[7:0];    // odd byte lane
      psram[rom.addr] = word;
    end
  end

  always @(posedge CLK2) begin
    if (!ram.we_n) sram[ram.addr] = ram.wdata;
  end

  // asynchronous read at the driven address
  always_comb rom_rdata = read_psram_word(rom.addr);
  always_comb ram_rdata = read_sram_byte(ram.addr);

endmodule

//--- testbench/tb_snes_mem_ctrl.sv
`timescale 1ns/1ps

module tb_snes_mem_ctrl
  import snes_mem_pkg::*;
();
  localparam int clk_period   = 8;
  localparam int access_limit = 40;  // cycles an MCU access may take
  // reset, sram, psram, back-pressure, passthrough, dead detection
  localparam int test_cycles  = 5 + 2 * 45 + 4 * 45 + 130 + 25 + 265;

  logic                   CLK2;
  logic                   arst_n;
  logic [snes_addr_w-1:0] snes_addr;
  logic                   snes_read_n;
  logic                   snes_write_n;
  logic                   snes_romsel_n;
  logic                   snes_cpu_clk;
  mcu_req_t               mcu_req;
  logic                   mcu_rdy;
  logic [7:0]             mcu_rdata;
  rom_pins_t              rom;
  logic [15:0]            rom_rdata;
  ram_pins_t              ram;
  logic [7:0]             ram_rdata;
  logic [7:0]             snes_data_out;
  logic                   snes_databus_oe_n;
  logic                   snes_reset;

  int                     errors;
  int                     tests_run;
  int                     tests_failed;
  logic [snes_addr_w-1:0] sram_addr;  // shared by the later SRAM tests
  logic [7:0]             sram_data;

  snes_mem_ctrl #(.DEAD_TIMEOUT(200)) i_snes_mem_ctrl (
    .CLK2, .arst_n, .snes_addr, .snes_read_n, .snes_write_n, .snes_romsel_n,
    .snes_cpu_clk, .mcu_req, .mcu_rdy, .mcu_rdata, .rom, .rom_rdata, .ram,
    .ram_rdata, .snes_data_out, .snes_databus_oe_n, .snes_reset
  );

  tb_mem_model i_mem_model (.CLK2, .rom, .rom_rdata, .ram, .ram_rdata);

  initial begin
    CLK2 = 1'b0;
    forever #(clk_period / 2) CLK2 = ~CLK2;
  end

  initial begin
    #(4 * test_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  // ------------------------------
  // reporting and helpers
  // ------------------------------
  task automatic mismatch(input string test, input logic [31:0] expected,
                          input logic [31:0] actual);
    $display("ERROR %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
    errors++;
  endtask

  task automatic fail_note(input string test, input string what);
    $display("%s: %s", test, what);
    errors++;
  endtask

  task automatic finish_test(input string test, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: passed", test);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test, errors - errors_before);
    end
  endtask

  task automatic clocks(input int n);
    repeat (n) @(posedge CLK2);
  endtask

  // one-cycle request pulse, as the MCU side expects
  task automatic send_req(input logic wr, input logic [snes_addr_w-1:0] addr,
                          input logic [7:0] data);
    @(posedge CLK2);
    mcu_req <= '{rrq: ~wr, wrq: wr, addr: addr, wdata: data};
    @(posedge CLK2);
    mcu_req.rrq <= 1'b0;
    mcu_req.wrq <= 1'b0;
  endtask

  task automatic wait_ready(input int limit, output bit ok);
    ok = 1'b0;
    repeat (limit) begin
      @(negedge CLK2);
      if (mcu_rdy) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  task automatic mcu_access(input string test, input logic wr,
                            input logic [snes_addr_w-1:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
    bit ok;
    wait_ready(access_limit, ok);
    if (!ok) fail_note(test, "MCU port was not ready for a new request");
    send_req(wr, addr, wdata);
    wait_ready(access_limit, ok);
    if (!ok) fail_note(test, "MCU ready did not return after the access");
    rdata = mcu_rdata;  // valid once ready is back
  endtask

  task automatic count_resets(input int cycles, output int pulses);
    pulses = 0;
    repeat (cycles) begin
      @(negedge CLK2);
      if (snes_reset) pulses++;
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_values();
    string name = "reset_values";
    int    err0;
    err0 = errors;
    @(negedge CLK2);
    if (mcu_rdy !== 1'b1) mismatch(name, 32'd1, 32'(mcu_rdy));
    if (rom.we_n !== 1'b1) mismatch(name, 32'd1, 32'(rom.we_n));
    if (ram.we_n !== 1'b1) mismatch(name, 32'd1, 32'(ram.we_n));
    if (rom.data_oe !== 1'b0) mismatch(name, 32'd0, 32'(rom.data_oe));
    if (ram.data_oe !== 1'b0) mismatch(name, 32'd0, 32'(ram.data_oe));
    if (snes_reset !== 1'b0) mismatch(name, 32'd0, 32'(snes_reset));
    finish_test(name, err0);
  endtask

  task automatic sram_round_trip();
    string      name = "sram_round_trip";
    int         err0;
    logic [7:0] got;
    err0 = errors;
    sram_addr = 24'h880000 | {5'b00000, 19'($urandom)};
    sram_data = 8'($urandom);
    mcu_access(name, 1'b1, sram_addr, sram_data, got);
    mcu_access(name, 1'b0, sram_addr, 8'h00, got);
    if (got !== sram_data) mismatch(name, 32'(sram_data), 32'(got));
    got = i_mem_model.read_sram_byte(sram_addr[18:0]);
    if (got !== sram_data) mismatch(name, 32'(sram_data), 32'(got));
    finish_test(name, err0);
  endtask

  task automatic psram_byte_lanes();
    string                  name = "psram_byte_lanes";
    int                     err0;
    logic [snes_addr_w-1:0] even_addr;
    logic [7:0]             even_byte;
    logic [7:0]             odd_byte;
    logic [7:0]             got;
    logic [15:0]            word;
    err0 = errors;
    even_addr = {4'h1, 20'($urandom) & 20'hFFFFE};  // banks 10-1F, outside the SRAM window
    even_byte = 8'($urandom);
    odd_byte  = 8'($urandom);
    mcu_access(name, 1'b1, even_addr, even_byte, got);
    mcu_access(name, 1'b1, even_addr | 24'h1, odd_byte, got);
    mcu_access(name, 1'b0, even_addr, 8'h00, got);
    if (got !== even_byte) mismatch(name, 32'(even_byte), 32'(got));
    mcu_access(name, 1'b0, even_addr | 24'h1, 8'h00, got);
    if (got !== odd_byte) mismatch(name, 32'(odd_byte), 32'(got));
    word = i_mem_model.read_psram_word(even_addr[snes_addr_w-1:1]);
    if (word !== {even_byte, odd_byte}) mismatch(name, {16'h0, even_byte, odd_byte}, 32'(word));
    finish_test(name, err0);
  endtask

  task automatic free_slot_backpressure();
    string name = "free_slot_backpressure";
    int    err0;
    int    early;
    bit    ok;
    err0  = errors;
    early = 0;
    @(posedge CLK2);
    snes_romsel_n <= 1'b0;  // SNES parked on the ROM window
    clocks(10);
    snes_cpu_clk <= 1'b1;   // SNES comes alive
    clocks(14);
    wait_ready(access_limit, ok);
    if (!ok) fail_note(name, "MCU port was not ready for a new request");
    send_req(1'b0, sram_addr, 8'h00);
    repeat (50) begin
      @(negedge CLK2);
      if (mcu_rdy) early++;
    end
    if (early != 0) fail_note(name, "MCU ready rose without a free slot");
    // one idle bus phase gives a pulse end
    @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    clocks(8);
    snes_cpu_clk <= 1'b1;
    wait_ready(access_limit, ok);
    if (!ok) fail_note(name, "MCU ready did not return after the pulse end");
    else if (mcu_rdata !== sram_data) mismatch(name, 32'(sram_data), 32'(mcu_rdata));
    finish_test(name, err0);
  endtask

  task automatic snes_read_passthrough();
    string name = "snes_read_passthrough";
    int    err0;
    err0 = errors;
    @(posedge CLK2);
    snes_addr     <= {5'b11000, sram_addr[18:0]};
    snes_read_n   <= 1'b0;
    snes_romsel_n <= 1'b0;
    repeat (10) @(negedge CLK2);  // sync chain has settled by now
    if (snes_databus_oe_n !== 1'b0) fail_note(name, "SNES data bus output was not enabled");
    else if (snes_data_out !== sram_data) mismatch(name, 32'(sram_data), 32'(snes_data_out));
    @(posedge CLK2);
    snes_read_n   <= 1'b1;
    snes_romsel_n <= 1'b1;
    clocks(10);
    finish_test(name, err0);
  endtask

  task automatic dead_revival();
    string name = "dead_revival";
    int    err0;
    int    pulses;
    err0 = errors;
    @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    clocks(230);  // past the 200 cycle timeout
    snes_cpu_clk <= 1'b1;
    count_resets(10, pulses);
    if (pulses != 1) mismatch(name, 32'd1, 32'(pulses));
    @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    clocks(10);
    snes_cpu_clk <= 1'b1;  // alive already, no reset expected
    count_resets(10, pulses);
    if (pulses != 0) mismatch(name, 32'd0, 32'(pulses));
    finish_test(name, err0);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    void'($urandom(38));
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    arst_n        = 1'b0;
    snes_addr     = '0;
    snes_read_n   = 1'b1;
    snes_write_n  = 1'b1;
    snes_romsel_n = 1'b1;
    snes_cpu_clk  = 1'b0;
    mcu_req       = '0;
    repeat (3) @(posedge CLK2);
    arst_n <= 1'b1;
    clocks(2);

    reset_values();
    sram_round_trip();
    psram_byte_lanes();
    free_slot_backpressure();
    snes_read_passthrough();
    dead_revival();

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/mcu_bridge.sv
`timescale 1ns/1ps

module mcu_bridge
  import snes_mem_pkg::*;
(
  input  logic      CLK2,
  input  logic      arst_n,
  input  mcu_req_t  mcu_req,
  output port_req_t rom_req,
  output port_req_t ram_req,
  input  logic      rom_done,
  input  logic      ram_done,
  input  logic [7:0] rom_rbyte,
  input  logic [7:0] ram_rbyte,
  output logic      mcu_rdy,
  output logic [7:0] mcu_rdata
);
  // index 0 is the PSRAM, index 1 the SRAM
  logic [1:0]             hit;
  logic [1:0]             done;
  logic [1:0]             rd_pend;
  logic [1:0]             wr_pend;
  logic [1:0]             rdy_q;
  logic [snes_addr_w-1:0] addr_q [2];
  logic [7:0]             data_q [2];
  logic                   ram_sel;

  assign ram_sel = (mcu_req.addr[snes_addr_w-1 -: 5] == ram_window);
  assign hit     = {ram_sel, ~ram_sel};
  assign done    = {ram_done, rom_done};

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= '0;
      wr_pend <= '0;
      rdy_q   <= '1;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (mcu_req.rrq && hit[i]) begin
          rd_pend[i] <= 1'b1;
          rdy_q[i]   <= 1'b0;
        end else if (mcu_req.wrq && hit[i]) begin
          wr_pend[i] <= 1'b1;
          rdy_q[i]   <= 1'b0;
        end else if (done[i]) begin
          rd_pend[i] <= 1'b0;
          wr_pend[i] <= 1'b0;
          rdy_q[i]   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK2) begin
    for (int i = 0; i < 2; i++) begin
      if ((mcu_req.rrq || mcu_req.wrq) && hit[i]) begin
        addr_q[i] <= mcu_req.addr;
        data_q[i] <= mcu_req.wdata;
      end
    end
    if (rom_done && rd_pend[0]) mcu_rdata <= rom_rbyte;
    else if (ram_done && rd_pend[1]) mcu_rdata <= ram_rbyte;
  end

  assign rom_req = '{rd_pend[0], wr_pend[0], addr_q[0], data_q[0]};
  assign ram_req = '{rd_pend[1], wr_pend[1], addr_q[1], data_q[1]};
  assign mcu_rdy = &rdy_q;

  // MCU side protocol: single request, only while ready
  a_mcu_req: assert property (@(posedge CLK2) disable iff (!arst_n)
    (mcu_req.rrq || mcu_req.wrq) |-> (mcu_rdy && !(mcu_req.rrq && mcu_req.wrq)));

endmodule

//--- verilog/ram_port.sv
`timescale 1ns/1ps

module ram_port
  import snes_mem_pkg::*;
#(
  parameter int RAM_CYCLE_LEN = 5
) (
  input  logic         CLK2,
  input  logic         arst_n,
  input  port_req_t    req,
  input  snes_bus_t    bus,
  input  snes_strobe_t strobe,
  input  logic         snes_dead,
  input  logic         snes_alive_edge,
  input  logic [7:0]   ram_rdata,
  output ram_pins_t    pins,
  output logic         done,
  output logic [7:0]   rbyte,
  output logic         free_slot,
  output logic [7:0]   snes_data_out,
  output logic         snes_databus_oe_n
);
  mem_state_e state;
  logic [3:0] delay_cnt;
  logic       free_q;
  logic       snes_rd_act;

  // ------------------------------
  // free slot detection
  // ------------------------------
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      free_q      <= 1'b0;
      snes_rd_act <= 1'b0;
    end else begin
      free_q <= strobe.cycle_start & bus.romsel_n & ~snes_rd_act;
      if (strobe.rd_start) snes_rd_act <= 1'b1;
      else if (strobe.rd_end || strobe.wr_end) snes_rd_act <= 1'b0;
      else if (bus.read_n && !bus.cpu_clk) snes_rd_act <= 1'b0;  // missed end edge
    end
  end

  assign free_slot = strobe.pulse_end | free_q;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state     <= idle;
      delay_cnt <= '0;
    end else if (snes_alive_edge) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (free_slot || snes_dead) begin
            if (req.rd_pend) begin
              state     <= rd_addr;
              delay_cnt <= 4'(RAM_CYCLE_LEN);
            end else if (req.wr_pend) begin
              state     <= wr_addr;
              delay_cnt <= 4'(RAM_CYCLE_LEN);
            end
          end
        end
        rd_addr, wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= (state == rd_addr) ? rd_end : wr_end;
        end
        default: state <= idle;
      endcase
    end
  end

  assign done = (state == rd_end) || (state == wr_end);

  always_ff @(posedge CLK2) begin
    if (state == rd_addr) rbyte <= ram_rdata;
  end

  // SNES owns the address while the port is idle
  assign pins.addr    = (state != idle) ? req.addr[ram_addr_w-1:0] : bus.addr[ram_addr_w-1:0];
  assign pins.we_n    = (state != wr_addr);
  assign pins.wdata   = req.data;
  assign pins.data_oe = (state == wr_addr) || (state == wr_end);

  assign snes_data_out     = ram_rdata;  // ROM window passthrough
  assign snes_databus_oe_n = bus.romsel_n | bus.read_n;

  // full cycle count reaches the counter on every start
  a_no_wrap: assert property (@(posedge CLK2) disable iff (!arst_n)
    ((state == rd_addr) || (state == wr_addr)) && ($past(state) == idle)
    |-> (int'(delay_cnt) == RAM_CYCLE_LEN));

endmodule

//--- verilog/rom_port.sv
`timescale 1ns/1ps

module rom_port
  import snes_mem_pkg::*;
#(
  parameter int ROM_CYCLE_LEN = 7
) (
  input  logic        CLK2,
  input  logic        arst_n,
  input  port_req_t   req,
  input  logic        free_slot,
  input  logic        snes_dead,
  input  logic        snes_alive_edge,
  input  logic [15:0] rom_rdata,
  output rom_pins_t   pins,
  output logic        done,
  output logic [7:0]  rbyte
);
  mem_state_e state;
  logic [3:0] delay_cnt;
  logic       lane_odd;

  assign lane_odd = req.addr[0];

  // ------------------------------
  // access FSM
  // ------------------------------
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state     <= idle;
      delay_cnt <= '0;
    end else if (snes_alive_edge) begin
      state <= idle;  // abort, request stays pending
    end else begin
      case (state)
        idle: begin
          if (free_slot || snes_dead) begin
            if (req.rd_pend) begin
              state     <= rd_addr;
              delay_cnt <= 4'(ROM_CYCLE_LEN);
            end else if (req.wr_pend) begin
              state     <= wr_addr;
              delay_cnt <= 4'(ROM_CYCLE_LEN);
            end
          end
        end
        rd_addr, wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= (state == rd_addr) ? rd_end : wr_end;
        end
        default: state <= idle;  // end states last one cycle
      endcase
    end
  end

  assign done = (state == rd_end) || (state == wr_end);

  // even byte sits in the upper half of the word
  always_ff @(posedge CLK2) begin
    if (state == rd_addr) rbyte <= lane_odd ? rom_rdata[7:0] : rom_rdata[15:8];
  end

  // ------------------------------
  // pin drive
  // ------------------------------
  assign pins.addr    = req.addr[snes_addr_w-1:1];
  assign pins.we_n    = (state != wr_addr);
  assign pins.bhe_n   = lane_odd;
  assign pins.ble_n   = ~lane_odd;
  assign pins.wdata   = lane_odd ? {8'h00, req.data} : {req.data, 8'h00};
  assign pins.data_oe = (state == wr_addr) || (state == wr_end);

  // a write strobe only ever belongs to a pending bridge write
  a_we_in_wr: assert property (@(posedge CLK2) disable iff (!arst_n)
    !pins.we_n |-> (state == wr_addr) && req.wr_pend);

endmodule

//--- verilog/snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync
  import snes_mem_pkg::*;
#(
  parameter int DEAD_TIMEOUT = 84000
) (
  input  logic                   CLK2,
  input  logic                   arst_n,
  input  logic [snes_addr_w-1:0] snes_addr,
  input  logic                   snes_read_n,
  input  logic                   snes_write_n,
  input  logic                   snes_romsel_n,
  input  logic                   snes_cpu_clk,
  output snes_bus_t              bus,
  output snes_strobe_t           strobe,
  output logic                   snes_dead,
  output logic                   snes_alive_edge,
  output logic                   snes_reset
);
  localparam int dead_cnt_w = $clog2(DEAD_TIMEOUT + 2);

  logic [6:0]             read_r;
  logic [6:0]             write_r;
  logic [6:0]             romsel_r;
  logic [6:0]             cpu_clk_r;
  logic [6:0]             pulse_r;
  logic [snes_addr_w-1:0] addr_r [7];
  logic [dead_cnt_w-1:0]  dead_cnt;
  logic                   pulse_in;

  // idle bus phase, clock low with no strobe
  assign pulse_in = snes_read_n & snes_write_n & ~snes_cpu_clk;

  // ------------------------------
  // input delay chains
  // ------------------------------
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      read_r    <= '1;
      write_r   <= '1;
      romsel_r  <= '1;
      cpu_clk_r <= '0;
      pulse_r   <= '1;
    end else begin
      read_r    <= {read_r[5:0], snes_read_n};
      write_r   <= {write_r[5:0], snes_write_n};
      romsel_r  <= {romsel_r[5:0], snes_romsel_n};
      cpu_clk_r <= {cpu_clk_r[5:0], snes_cpu_clk};
      pulse_r   <= {pulse_r[5:0], pulse_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr;
    for (int i = 1; i < 7; i++) begin
      addr_r[i] <= addr_r[i-1];
    end
  end

  // two-tap filter against bus glitches
  assign bus.addr     = addr_r[6] & addr_r[5];
  assign bus.read_n   = read_r[6] & read_r[5];
  assign bus.write_n  = write_r[6] & write_r[5];
  assign bus.romsel_n = romsel_r[6] & romsel_r[5];
  assign bus.cpu_clk  = cpu_clk_r[6] & cpu_clk_r[5];

  assign strobe.rd_start    = (read_r[6:1] == 6'b111110);
  assign strobe.rd_end      = (read_r[6:1] == 6'b000001);
  assign strobe.wr_end      = (write_r[6:1] == 6'b000001);
  assign strobe.cycle_start = (cpu_clk_r[6:1] == 6'b000001);
  assign strobe.pulse_end   = (pulse_r[6:1] == 6'b000011);

  // ------------------------------
  // dead detection
  // ------------------------------
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt <= '0;
    end else if (cpu_clk_r[1]) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= dead_cnt_w'(DEAD_TIMEOUT)) begin
      dead_cnt <= dead_cnt + 1'b1;  // saturates one past timeout
    end
  end

  assign snes_alive_edge = snes_dead & cpu_clk_r[1];

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      snes_dead  <= 1'b1;  // no SNES seen yet
      snes_reset <= 1'b0;
    end else begin
      snes_reset <= snes_alive_edge;
      if (cpu_clk_r[1]) snes_dead <= 1'b0;
      else if (dead_cnt > dead_cnt_w'(DEAD_TIMEOUT)) snes_dead <= 1'b1;
    end
  end

  // revival reset is a single pulse
  a_reset_pulse: assert property (@(posedge CLK2) disable iff (!arst_n)
    snes_reset |=> !snes_reset);

endmodule

//--- verilog/snes_mem_ctrl.sv
`timescale 1ns/1ps

module snes_mem_ctrl
  import snes_mem_pkg::*;
#(
  parameter int ROM_CYCLE_LEN = 7,
  parameter int RAM_CYCLE_LEN = 5,
  parameter int DEAD_TIMEOUT  = 84000
) (
  input  logic                   CLK2,
  input  logic                   arst_n,
  input  logic [snes_addr_w-1:0] snes_addr,
  input  logic                   snes_read_n,
  input  logic                   snes_write_n,
  input  logic                   snes_romsel_n,
  input  logic                   snes_cpu_clk,
  input  mcu_req_t               mcu_req,
  output logic                   mcu_rdy,
  output logic [7:0]             mcu_rdata,
  output rom_pins_t              rom,
  input  logic [15:0]            rom_rdata,
  output ram_pins_t              ram,
  input  logic [7:0]             ram_rdata,
  output logic [7:0]             snes_data_out,
  output logic                   snes_databus_oe_n,
  output logic                   snes_reset
);
  snes_bus_t    bus;
  snes_strobe_t strobe;
  port_req_t    rom_req;
  port_req_t    ram_req;
  logic         snes_dead;
  logic         snes_alive_edge;
  logic         free_slot;
  logic         rom_done;
  logic         ram_done;
  logic [7:0]   rom_rbyte;
  logic [7:0]   ram_rbyte;

  snes_bus_sync #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) i_snes_bus_sync (
    .CLK2, .arst_n, .snes_addr, .snes_read_n, .snes_write_n, .snes_romsel_n,
    .snes_cpu_clk, .bus, .strobe, .snes_dead, .snes_alive_edge, .snes_reset
  );

  mcu_bridge i_mcu_bridge (
    .CLK2, .arst_n, .mcu_req, .rom_req, .ram_req, .rom_done, .ram_done,
    .rom_rbyte, .ram_rbyte, .mcu_rdy, .mcu_rdata
  );

  // PSRAM shares the SRAM slot rule
  rom_port #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) i_rom_port (
    .CLK2, .arst_n, .req(rom_req), .free_slot, .snes_dead, .snes_alive_edge,
    .rom_rdata, .pins(rom), .done(rom_done), .rbyte(rom_rbyte)
  );

  ram_port #(.RAM_CYCLE_LEN(RAM_CYCLE_LEN)) i_ram_port (
    .CLK2, .arst_n, .req(ram_req), .bus, .strobe, .snes_dead, .snes_alive_edge,
    .ram_rdata, .pins(ram), .done(ram_done), .rbyte(ram_rbyte), .free_slot,
    .snes_data_out, .snes_databus_oe_n
  );

endmodule

//--- verilog/snes_mem_pkg.sv
package snes_mem_pkg;

  // ------------------------------
  // widths and address windows
  // ------------------------------
  localparam int snes_addr_w = 24;  // SNES and MCU byte address
  localparam int rom_addr_w  = 23;  // PSRAM word address
  localparam int ram_addr_w  = 19;  // 512KB SRAM

  // MCU 880000-8FFFFF goes to SRAM, anything else to PSRAM
  localparam logic [4:0] ram_window = 5'b10001;

  // access states, shared by both memory ports
  typedef enum logic [2:0] {
    idle,
    rd_addr,
    rd_end,
    wr_addr,
    wr_end
  } mem_state_e;

  // ------------------------------
  // bus bundles
  // ------------------------------
  typedef struct packed {
    logic                   rrq;    // one-cycle read request
    logic                   wrq;    // one-cycle write request
    logic [snes_addr_w-1:0] addr;
    logic [7:0]             wdata;
  } mcu_req_t;

  typedef struct packed {
    logic [snes_addr_w-1:0] addr;
    logic                   read_n;
    logic                   write_n;
    logic                   romsel_n;
    logic                   cpu_clk;
  } snes_bus_t;

  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;
    logic pulse_end;
  } snes_strobe_t;

  typedef struct packed {
    logic                   rd_pend;
    logic                   wr_pend;
    logic [snes_addr_w-1:0] addr;
    logic [7:0]             data;
  } port_req_t;

  typedef struct packed {
    logic [rom_addr_w-1:0] addr;
    logic                  we_n;
    logic                  bhe_n;
    logic                  ble_n;
    logic [15:0]           wdata;
    logic                  data_oe;
  } rom_pins_t;

  typedef struct packed {
    logic [ram_addr_w-1:0] addr;
    logic                  we_n;
    logic [7:0]            wdata;
    logic                  data_oe;
  } ram_pins_t;

endpackage
